/* Makefile */
SRCS := $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: run clean

obj_dir/Vpcie_os_tx_tb: build.f $(SRCS)
	verilator --binary --timing --assert --top-module pcie_os_tx_tb -f build.f

run: obj_dir/Vpcie_os_tx_tb
	out="$$(./obj_dir/Vpcie_os_tx_tb)"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* bench/pcie_os_tx_checker.sv */
`timescale 1ns/1ps
`include "pcie_phy_defines.svh"

module pcie_os_tx_checker
  import pcie_phy_pkg::*;
(
  input logic     clk_i,
  input logic     rst_i,
  input logic     cmd_valid_i,
  input os_cmd_t  cmd_i,
  input logic     cmd_ready_i,
  input os_beat_t gen_beat_i,
  input logic     gen_valid_i,
  input logic     gen_ready_i,
  input os_beat_t buf_beat_i,
  input logic     buf_valid_i,
  input logic     buf_ready_i,
  input logic     sym_valid_i
);

  // read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // command held until the generator takes it
  cmd_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_valid_i && !cmd_ready_i |=> cmd_valid_i && $stable(cmd_i))
    else begin
      fail_cnt <= fail_cnt + 1;
      $error("command dropped or changed while waiting for cmd_ready_o");
    end

  gen_beat_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    gen_valid_i && !gen_ready_i |=> gen_valid_i && $stable(gen_beat_i))
    else begin
      fail_cnt <= fail_cnt + 1;
      $error("generator beat dropped or changed while stalled");
    end

  buf_beat_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    buf_valid_i && !buf_ready_i |=> buf_valid_i && $stable(buf_beat_i))
    else begin
      fail_cnt <= fail_cnt + 1;
      $error("buffer beat dropped or changed while stalled");
    end

  // idle outputs one cycle into reset
  reset_state_a: assert property (@(posedge clk_i)
    rst_i |=> !sym_valid_i && cmd_ready_i)
    else begin
      fail_cnt <= fail_cnt + 1;
      $error("outputs not idle after reset");
    end

endmodule

/* bench/pcie_os_tx_tb.sv */
`timescale 1ns/1ps
`include "pcie_phy_defines.svh"

module pcie_os_tx_tb
  import pcie_phy_pkg::*;
();

  typedef lane_sym_t [`NUM_LANES-1:0] lane_syms_t;

  // one stimulus row with its expected values
  typedef struct packed {
    os_cmd_t                    cmd;
    logic [`NUM_LANES-1:0][3:0] presets;
    logic [7:0]                 sym0;
    logic [7:0]                 id;
    logic [15:0]                kmask;
  } stim_row_t;

  localparam int NUM_ROWS = 6;
  localparam int TIMEOUT  = 2000;

  logic                       clk_i       = 1'b0;
  logic                       rst_i       = 1'b1;
  logic                       cmd_valid_i = 1'b0;
  os_cmd_t                    cmd_i       = '0;
  logic                       cmd_ready_o;
  logic [`NUM_LANES-1:0][3:0] preset_i    = '0;
  logic                       phy_ready_i = 1'b1;
  lane_sym_t [`NUM_LANES-1:0] sym_o;
  logic                       sym_valid_o;
  logic                       os_sent_o;

  stim_row_t  rows [NUM_ROWS];
  lane_syms_t sym_q [$];
  logic [31:0] rnd_state  = 32'h0dc3_ab3d;
  logic        rand_ready = 1'b0;
  int err_cnt    = 0;
  int check_cnt  = 0;
  int test_cnt   = 0;
  int fail_tests = 0;
  int sent_cnt   = 0;
  int accept_cnt = 0;
  int cmd_cnt    = 0;

  pcie_os_tx UUT (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cmd_valid_i(cmd_valid_i),
    .cmd_i      (cmd_i),
    .cmd_ready_o(cmd_ready_o),
    .preset_i   (preset_i),
    .phy_ready_i(phy_ready_i),
    .sym_o      (sym_o),
    .sym_valid_o(sym_valid_o),
    .os_sent_o  (os_sent_o)
  );

  bind pcie_os_tx pcie_os_tx_checker u_checker (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cmd_valid_i(cmd_valid_i),
    .cmd_i      (cmd_i),
    .cmd_ready_i(cmd_ready_o),
    .gen_beat_i (gen_beat),
    .gen_valid_i(gen_valid),
    .gen_ready_i(gen_ready),
    .buf_beat_i (buf_beat),
    .buf_valid_i(buf_valid),
    .buf_ready_i(buf_ready),
    .sym_valid_i(sym_valid_o)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // PHY stalls about a quarter of the time in random mode
  always @(posedge clk_i) begin
    rnd_state   <= xorshift32(rnd_state);
    phy_ready_i <= rand_ready ? (rnd_state[1:0] != 2'b00) : 1'b1;
  end

  // symbol collector and handshake counters
  always @(posedge clk_i) begin
    if (!rst_i && sym_valid_o && phy_ready_i) begin
      sym_q.push_back(sym_o);
    end
    if (!rst_i && os_sent_o) begin
      sent_cnt++;
    end
    if (!rst_i && cmd_valid_i && cmd_ready_o) begin
      accept_cnt++;
    end
  end

  // expected symbol s of one lane, straight from the symbol rules
  function automatic lane_sym_t ref_sym(input stim_row_t row, input int lane, input int s);
    lane_sym_t r;
    r.data = 8'h00;
    r.is_k = 1'b0;
    if (row.cmd.op == OP_EIOS) begin
      r.data = (s == 0) ? `SYM_COM : `SYM_IDL;
      r.is_k = 1'b1;
    end else if (row.cmd.op != OP_IDLE) begin
      case (s)
        0: begin
          r.data = `SYM_COM;
          r.is_k = 1'b1;
        end
        1: begin
          r.data = row.cmd.pad_link ? `SYM_PAD : row.cmd.link_num;
          r.is_k = row.cmd.pad_link;
        end
        2: begin
          r.data = row.cmd.set_lane ? lane[7:0] : `SYM_PAD;
          r.is_k = !row.cmd.set_lane;
        end
        3: r.data = row.cmd.n_fts;
        4: r.data = row.cmd.rate;
        5: r.data = 8'h00;
        6: r.data = {row.cmd.ec, 2'b00, (row.cmd.ec != 2'b00) ? row.presets[lane] : 4'h0};
        default: r.data = (row.cmd.op == OP_TS2) ? `TS2_ID : `TS1_ID;
      endcase
    end
    return r;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic send_cmd(input stim_row_t row);
    int   cycles;
    logic accepted;
    cycles   = 0;
    accepted = 1'b0;
    cmd_cnt++;
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_i       <= row.cmd;
    preset_i    <= row.presets;
    while (!accepted && cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
      accepted = cmd_ready_o;
    end
    cmd_valid_i <= 1'b0;
    if (!accepted) begin
      err_cnt++;
      $display("command was never accepted by the DUT");
    end
  endtask

  task automatic wait_syms(input int n, input string what);
    int cycles;
    cycles = 0;
    while (sym_q.size() < n && cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (sym_q.size() < n) begin
      err_cnt++;
      $display("timeout while waiting for %s", what);
    end
  endtask

  task automatic check_set(input stim_row_t row);
    lane_syms_t got;
    lane_sym_t  exp;
    if (sym_q.size() < `OS_SYMS) begin
      err_cnt++;
      $display("ordered set incomplete, only %0d symbol cycles collected", sym_q.size());
    end else begin
      for (int s = 0; s < `OS_SYMS; s++) begin
        got = sym_q.pop_front();
        for (int l = 0; l < `NUM_LANES; l++) begin
          exp = ref_sym(row, l, s);
          compare($sformatf("sym_o[%0d].data (symbol %0d)", l, s),
                  32'(got[l].data), 32'(exp.data));
          compare($sformatf("sym_o[%0d].is_k (symbol %0d)", l, s),
                  32'(got[l].is_k), 32'(exp.is_k));
        end
        // table columns as a second opinion
        compare($sformatf("sym_o[0].is_k vs table (symbol %0d)", s),
                32'(got[0].is_k), 32'(row.kmask[s]));
        if (s == 0) begin
          compare("sym_o[0].data symbol 0 vs table", 32'(got[0].data), 32'(row.sym0));
        end
        if (s == 7) begin
          compare("sym_o[0].data symbol 7 vs table", 32'(got[0].data), 32'(row.id));
        end
      end
    end
  endtask

  task automatic run_rows(input int first, input int last);
    for (int r = first; r <= last; r++) begin
      send_cmd(rows[r]);
      wait_syms(`OS_SYMS, "the symbols of an ordered set");
      check_set(rows[r]);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_i <= 1'b1;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d, %s: ok", test_cnt, name);
    end else begin
      fail_tests++;
      $display("test %0d, %s: FAILED with %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  initial begin
    int e;
    rows[0] = '{cmd: '{OP_TS1, 8'h05, 1'b0, 1'b1, 8'h1F, 8'h02, 2'b00},
                presets: 16'h4321, sym0: 8'hBC, id: 8'h4A, kmask: 16'h0001};
    rows[1] = '{cmd: '{OP_TS2, 8'h3C, 1'b0, 1'b1, 8'h80, 8'h06, 2'b00},
                presets: 16'h8765, sym0: 8'hBC, id: 8'h45, kmask: 16'h0001};
    rows[2] = '{cmd: '{OP_TS1, 8'h11, 1'b1, 1'b0, 8'h10, 8'h0E, 2'b10},
                presets: 16'h9A5C, sym0: 8'hBC, id: 8'h4A, kmask: 16'h0007};
    rows[3] = '{cmd: '{OP_IDLE, 8'h22, 1'b0, 1'b0, 8'h33, 8'h44, 2'b11},
                presets: 16'hFFFF, sym0: 8'h00, id: 8'h00, kmask: 16'h0000};
    rows[4] = '{cmd: '{OP_EIOS, 8'h00, 1'b0, 1'b0, 8'h00, 8'h00, 2'b00},
                presets: 16'h0000, sym0: 8'hBC, id: 8'h7C, kmask: 16'hFFFF};
    rows[5] = '{cmd: '{OP_TS2, 8'h7E, 1'b1, 1'b1, 8'h2A, 8'h1E, 2'b01},
                presets: 16'h7E3B, sym0: 8'hBC, id: 8'h45, kmask: 16'h0003};

    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;

    e = err_cnt;
    run_rows(0, 1);
    end_test("TS1 and TS2 with link and lane numbers", e);

    e = err_cnt;
    run_rows(2, 2);
    end_test("PAD link and lane with per-lane presets", e);

    e = err_cnt;
    run_rows(3, 4);
    end_test("IDLE and EIOS sets", e);

    // random PHY stalls, commands issued as soon as the generator is free
    e = err_cnt;
    rand_ready <= 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      send_cmd(rows[r]);
    end
    wait_syms(NUM_ROWS * `OS_SYMS, "the back-to-back ordered sets");
    for (int r = 0; r < NUM_ROWS; r++) begin
      check_set(rows[r]);
    end
    end_test("back-pressure with back-to-back commands", e);

    e = err_cnt;
    repeat (4) @(posedge clk_i);
    compare("os_sent_o pulse count", 32'(sent_cnt), 32'(accept_cnt));
    compare("accepted command count", 32'(accept_cnt), 32'(cmd_cnt));
    compare("symbol cycles beyond the last set", 32'(sym_q.size()), 32'd0);
    end_test("one completion pulse per command", e);

    e = err_cnt;
    send_cmd(rows[0]);
    wait_syms(6, "the first symbols of the interrupted set");
    apply_reset();
    @(posedge clk_i);
    compare("sym_valid_o", 32'(sym_valid_o), 32'd0);
    compare("cmd_ready_o", 32'(cmd_ready_o), 32'd1);
    compare("os_sent_o", 32'(os_sent_o), 32'd0);
    sym_q.delete();
    run_rows(5, 5);
    end_test("reset in the middle of a set", e);

    err_cnt = err_cnt + int'(UUT.u_checker.fail_cnt);
    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             test_cnt, fail_tests, check_cnt, err_cnt);
    if (err_cnt == 0 && fail_tests == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+src
src/pcie_phy_pkg.sv
src/os_generator.sv
src/os_skid_buffer.sv
src/lane_serializer.sv
src/pcie_os_tx.sv
bench/pcie_os_tx_checker.sv
bench/pcie_os_tx_tb.sv

/* src/lane_serializer.sv */
`timescale 1ns/1ps
`include "pcie_phy_defines.svh"

module lane_serializer
  import pcie_phy_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  os_beat_t                     beat_i,
  input  logic                         beat_valid_i,
  output logic                         beat_ready_o,
  input  logic                         phy_ready_i,
  output lane_sym_t [`NUM_LANES-1:0]   sym_o,
  output logic                         sym_valid_o
);

  os_beat_t   cur_r;
  logic       cur_valid_r;
  logic [1:0] idx_r;
  logic       advance;
  logic       last_sym;
  logic       load;

  assign advance  = cur_valid_r && phy_ready_i;
  assign last_sym = (idx_r == 2'd3);
  // refill on the final symbol so the output stays gapless
  assign beat_ready_o = !cur_valid_r || (advance && last_sym);
  assign load         = beat_valid_i && beat_ready_o;

  assign sym_valid_o = cur_valid_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cur_valid_r <= 1'b0;
      idx_r       <= '0;
    end else begin
      if (load) begin
        cur_valid_r <= 1'b1;
        idx_r       <= '0;
      end else if (advance) begin
        idx_r <= idx_r + 2'd1;
        if (last_sym) begin
          cur_valid_r <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      cur_r <= beat_i;
    end
  end

  // byte idx_r of every lane, K flag shared
  always_comb begin
    for (int l = 0; l < `NUM_LANES; l++) begin
      sym_o[l].data = cur_r.data[l*32 + idx_r*`SYM_W +: `SYM_W];
      sym_o[l].is_k = cur_r.kmask[idx_r];
    end
  end

endmodule

/* src/os_generator.sv */
`timescale 1ns/1ps
`include "pcie_phy_defines.svh"

module os_generator
  import pcie_phy_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          cmd_valid_i,
  input  os_cmd_t                       cmd_i,
  output logic                          cmd_ready_o,
  input  logic [`NUM_LANES-1:0][3:0]    preset_i,
  output os_beat_t                      beat_o,
  output logic                          beat_valid_o,
  input  logic                          beat_ready_i,
  output logic                          os_sent_o
);

  os_gen_state_e state_r;
  os_cmd_t       cmd_r;
  logic [1:0]    beat_cnt_r;
  logic          os_sent_r;
  logic          cmd_fire;
  logic          beat_fire;
  logic [`SYM_W-1:0] ts_id;

  // full ordered set per lane, symbol 0 in the low byte
  logic [`NUM_LANES-1:0][`OS_SYMS-1:0][`SYM_W-1:0] set_r;
  logic [`NUM_LANES-1:0][`OS_SYMS-1:0][`SYM_W-1:0] set_c;
  logic [`OS_SYMS-1:0] kmask_r;
  logic [`OS_SYMS-1:0] kmask_c;

  assign cmd_ready_o  = (state_r == ST_IDLE);
  assign beat_valid_o = (state_r == ST_SEND);
  assign cmd_fire     = cmd_valid_i && cmd_ready_o;
  assign beat_fire    = beat_valid_o && beat_ready_i;
  assign os_sent_o    = os_sent_r;

  // set builder, works from the registered command
  always_comb begin
    ts_id   = (cmd_r.op == OP_TS2) ? `TS2_ID : `TS1_ID;
    set_c   = '0;
    kmask_c = '0;
    case (cmd_r.op)
      OP_TS1, OP_TS2: begin
        kmask_c[0] = 1'b1;
        // PAD is a K symbol wherever it lands
        kmask_c[1] = cmd_r.pad_link;
        kmask_c[2] = !cmd_r.set_lane;
        for (int l = 0; l < `NUM_LANES; l++) begin
          set_c[l][0] = `SYM_COM;
          set_c[l][1] = cmd_r.pad_link ? `SYM_PAD : cmd_r.link_num;
          set_c[l][2] = cmd_r.set_lane ? 8'(l) : `SYM_PAD;
          set_c[l][3] = cmd_r.n_fts;
          set_c[l][4] = cmd_r.rate;
          set_c[l][5] = '0;
          set_c[l][6] = {cmd_r.ec, 2'b00, (cmd_r.ec != 2'b00) ? preset_i[l] : 4'h0};
          for (int s = 7; s < `OS_SYMS; s++) begin
            set_c[l][s] = ts_id;
          end
        end
      end
      OP_EIOS: begin
        kmask_c = '1;
        for (int l = 0; l < `NUM_LANES; l++) begin
          set_c[l][0] = `SYM_COM;
          for (int s = 1; s < `OS_SYMS; s++) begin
            set_c[l][s] = `SYM_IDL;
          end
        end
      end
      default: begin
        // logical idle, all zero data symbols
        set_c   = '0;
        kmask_c = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r    <= ST_IDLE;
      beat_cnt_r <= '0;
      os_sent_r  <= 1'b0;
    end else begin
      os_sent_r <= beat_fire && (beat_cnt_r == 2'd3);
      case (state_r)
        ST_IDLE: begin
          if (cmd_fire) begin
            state_r <= ST_BUILD;
          end
        end
        ST_BUILD: begin
          beat_cnt_r <= '0;
          state_r    <= ST_SEND;
        end
        ST_SEND: begin
          if (beat_fire) begin
            beat_cnt_r <= beat_cnt_r + 2'd1;
            if (beat_cnt_r == 2'd3) begin
              state_r <= ST_IDLE;
            end
          end
        end
        default: state_r <= ST_IDLE;
      endcase
    end
  end

  // command and set storage
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      cmd_r <= cmd_i;
    end
    // presets are sampled here
    if (state_r == ST_BUILD) begin
      set_r   <= set_c;
      kmask_r <= kmask_c;
    end
  end

  // slice out the current beat
  always_comb begin
    for (int l = 0; l < `NUM_LANES; l++) begin
      beat_o.data[l*32 +: 32] = set_r[l][beat_cnt_r*`BEAT_SYMS +: `BEAT_SYMS];
    end
    beat_o.kmask = kmask_r[beat_cnt_r*`BEAT_SYMS +: `BEAT_SYMS];
    beat_o.last  = (beat_cnt_r == 2'd3);
  end

endmodule

/* src/os_skid_buffer.sv */
`timescale 1ns/1ps

module os_skid_buffer
  import pcie_phy_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  os_beat_t s_beat_i,
  input  logic     s_valid_i,
  output logic     s_ready_o,
  output os_beat_t m_beat_o,
  output logic     m_valid_o,
  input  logic     m_ready_i
);

  os_beat_t out_r;
  logic     out_valid_r;
  os_beat_t skid_r;
  logic     skid_valid_r;
  logic     s_fire;
  logic     out_free;

  // upstream only sees the skid flag, a register
  assign s_ready_o = !skid_valid_r;
  assign s_fire    = s_valid_i && s_ready_o;
  assign out_free  = m_ready_i || !out_valid_r;

  assign m_beat_o  = out_r;
  assign m_valid_o = out_valid_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_r  <= 1'b0;
      skid_valid_r <= 1'b0;
    end else begin
      if (out_free) begin
        // skid entry is older, drain it first
        if (skid_valid_r) begin
          out_valid_r  <= 1'b1;
          skid_valid_r <= 1'b0;
        end else begin
          out_valid_r <= s_fire;
        end
      end else if (s_fire) begin
        skid_valid_r <= 1'b1;
      end
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (out_free) begin
      if (skid_valid_r) begin
        out_r <= skid_r;
      end else if (s_fire) begin
        out_r <= s_beat_i;
      end
    end else if (s_fire) begin
      skid_r <= s_beat_i;
    end
  end

endmodule

/* src/pcie_os_tx.sv */
`timescale 1ns/1ps
`include "pcie_phy_defines.svh"

module pcie_os_tx
  import pcie_phy_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         cmd_valid_i,
  input  os_cmd_t                      cmd_i,
  output logic                         cmd_ready_o,
  input  logic [`NUM_LANES-1:0][3:0]   preset_i,
  input  logic                         phy_ready_i,
  output lane_sym_t [`NUM_LANES-1:0]   sym_o,
  output logic                         sym_valid_o,
  output logic                         os_sent_o
);

  // generator to buffer
  os_beat_t gen_beat;
  logic     gen_valid;
  logic     gen_ready;

  // buffer to serializer
  os_beat_t buf_beat;
  logic     buf_valid;
  logic     buf_ready;

  os_generator u_gen (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cmd_ready_o (cmd_ready_o),
    .preset_i    (preset_i),
    .beat_o      (gen_beat),
    .beat_valid_o(gen_valid),
    .beat_ready_i(gen_ready),
    .os_sent_o   (os_sent_o)
  );

  os_skid_buffer u_skid (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .s_beat_i (gen_beat),
    .s_valid_i(gen_valid),
    .s_ready_o(gen_ready),
    .m_beat_o (buf_beat),
    .m_valid_o(buf_valid),
    .m_ready_i(buf_ready)
  );

  lane_serializer u_ser (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .beat_i      (buf_beat),
    .beat_valid_i(buf_valid),
    .beat_ready_o(buf_ready),
    .phy_ready_i (phy_ready_i),
    .sym_o       (sym_o),
    .sym_valid_o (sym_valid_o)
  );

endmodule

/* src/pcie_phy_defines.svh */
`ifndef PCIE_PHY_DEFINES_SVH
`define PCIE_PHY_DEFINES_SVH

// number of lanes in the link
`define NUM_LANES 4

// one symbol before 8b/10b encoding
`define SYM_W 8

// K-symbol codes
`define SYM_COM 8'hBC
`define SYM_PAD 8'hF7
`define SYM_IDL 8'h7C

// training set identifiers, symbols 7 to 15
`define TS1_ID 8'h4A
`define TS2_ID 8'h45

// symbols per ordered set and per beat
`define OS_SYMS   16
`define BEAT_SYMS 4

`endif

/* src/pcie_phy_pkg.sv */
`include "pcie_phy_defines.svh"

package pcie_phy_pkg;

  // ordered set requested by the training controller
  typedef enum logic [1:0] {
    OP_TS1  = 2'd0,
    OP_TS2  = 2'd1,
    OP_IDLE = 2'd2,
    OP_EIOS = 2'd3
  } os_op_e;

  // generator FSM
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_BUILD = 2'd1,
    ST_SEND  = 2'd2
  } os_gen_state_e;

  // one command per ordered set, 30 bits
  typedef struct packed {
    os_op_e      op;
    logic [7:0]  link_num;
    // send PAD instead of link_num
    logic        pad_link;
    // put the lane index into symbol 2
    logic        set_lane;
    logic [7:0]  n_fts;
    logic [7:0]  rate;
    // equalization control, symbol 6 bits 7:6
    logic [1:0]  ec;
  } os_cmd_t;

  // four symbols of every lane, lane 0 in the low word
  typedef struct packed {
    logic [`NUM_LANES*`BEAT_SYMS*`SYM_W-1:0] data;
    // one bit per byte position, shared by all lanes
    logic [`BEAT_SYMS-1:0]                   kmask;
    logic                                    last;
  } os_beat_t;

  // symbol handed to the PHY on one lane
  typedef struct packed {
    logic [`SYM_W-1:0] data;
    logic              is_k;
  } lane_sym_t;

endpackage
